// ==== logic/imuldiv_pkg.sv ====
// --------------------
// shared sizes, function encoding, request and response types
// for the iterative multiply/divide unit
// --------------------

package imuldiv_pkg;

  // --------------------
  // sizes
  // --------------------

  // operand width
  localparam int data_w = 32;
  // full product, also the packed response width
  localparam int prod_w = 2 * data_w;
  // one add/shift or subtract/shift step per operand bit
  localparam int step_count = 32;
  // counter covers 0..step_count, the last value is the result cycle
  localparam int cnt_w = $clog2(step_count + 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(step_count);

  // --------------------
  // request
  // --------------------

  // bit 1 picks the divider, bit 0 set means unsigned
  typedef enum logic [1:0] {
    func_mul  = 2'd0,
    func_mulu = 2'd1,
    func_div  = 2'd2,
    func_divu = 2'd3
  } muldiv_func_e;

  // for divide, a is the dividend and b the divisor
  typedef struct packed {
    muldiv_func_e      func;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
  } muldiv_req_t;

  // --------------------
  // response
  // --------------------

  // remainder sits in the upper half
  typedef struct packed {
    logic [data_w-1:0] rem;
    logic [data_w-1:0] quot;
  } div_result_t;

  // same 64-bit word, read as a product or as quotient/remainder
  typedef union packed {
    logic [prod_w-1:0] product;
    div_result_t       div;
  } muldiv_resp_u;

endpackage

// ==== logic/int_mul_dpath.sv ====
// --------------------
// multiplier datapath: operand magnitude registers,
// shift-add accumulator and sign restore into the result register
// --------------------

`timescale 1ns/1ps

module int_mul_dpath (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [imuldiv_pkg::data_w-1:0] a,
  input  logic [imuldiv_pkg::data_w-1:0] b,
  input  logic                           is_signed,
  input  logic                           a_en,
  input  logic                           a_mux_sel,
  input  logic                           b_en,
  input  logic                           b_mux_sel,
  input  logic                           result_en,
  output logic [imuldiv_pkg::prod_w-1:0] result
);

  // multiplicand, widened so it can move left over all 32 steps
  logic [imuldiv_pkg::prod_w-1:0] a_reg;
  // multiplier, consumed from the low bit
  logic [imuldiv_pkg::data_w-1:0] b_reg;
  logic [imuldiv_pkg::prod_w-1:0] acc_reg;
  // product must be negated at the end
  logic                           neg_reg;

  logic                           a_sign;
  logic                           b_sign;
  logic [imuldiv_pkg::data_w-1:0] a_mag;
  logic [imuldiv_pkg::data_w-1:0] b_mag;
  logic [imuldiv_pkg::prod_w-1:0] a_mux_out;
  logic [imuldiv_pkg::data_w-1:0] b_mux_out;
  logic [imuldiv_pkg::prod_w-1:0] acc_next;

  // --------------------
  // operand load
  // --------------------

  // sign only counts for the signed functions
  assign a_sign = is_signed & a[imuldiv_pkg::data_w-1];
  assign b_sign = is_signed & b[imuldiv_pkg::data_w-1];

  // two's complement magnitude, most negative value maps onto itself
  assign a_mag = a_sign ? (~a + 1'b1) : a;
  assign b_mag = b_sign ? (~b + 1'b1) : b;

  // sel low loads, sel high shifts
  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{imuldiv_pkg::data_w{1'b0}}, a_mag};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : b_mag;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
    // sign restore happens once, on the result cycle
    if (result_en) begin
      result <= neg_reg ? (~acc_reg + 1'b1) : acc_reg;
    end
  end

  // --------------------
  // accumulator
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg <= '0;
      neg_reg <= 1'b0;
    end else if (a_en) begin
      if (!a_mux_sel) begin
        // load cycle clears the sum and latches the result sign
        acc_reg <= '0;
        neg_reg <= a_sign ^ b_sign;
      end else begin
        acc_reg <= acc_next;
      end
    end
  end

endmodule

// ==== logic/int_mul_ctrl.sv ====
// --------------------
// multiplier control FSM: step counter, handshake outputs
// and datapath enables
// --------------------

`timescale 1ns/1ps

module int_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel,
  output logic result_en
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e                        state;
  // counts steps 0..31, value 32 is the result cycle
  logic [imuldiv_pkg::cnt_w-1:0] count;
  logic                          req_go;
  logic                          resp_go;
  logic                          last;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;
  assign last    = (count == imuldiv_pkg::cnt_last);

  // --------------------
  // state and counter
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // result waits here under back-pressure
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    a_mux_sel = 1'b0;
    b_en      = 1'b0;
    b_mux_sel = 1'b0;
    result_en = 1'b0;
    case (state)
      st_idle: begin
        // ready is high here, so valid alone marks the accepting edge
        req_rdy = 1'b1;
        a_en    = req_val;
        b_en    = req_val;
      end
      st_calc: begin
        // 32 shift/add steps, then one cycle to latch the signed result
        a_en      = !last;
        a_mux_sel = 1'b1;
        b_en      = !last;
        b_mux_sel = 1'b1;
        result_en = last;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/int_div_iterative.sv ====
// --------------------
// restoring divider with its own FSM, magnitude handling,
// divide-by-zero rule and sign restore
// --------------------

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [imuldiv_pkg::data_w-1:0] a,
  input  logic [imuldiv_pkg::data_w-1:0] b,
  input  logic                           is_signed,
  input  logic                           req_val,
  output logic                           req_rdy,
  output logic                           resp_val,
  input  logic                           resp_rdy,
  output imuldiv_pkg::div_result_t       result
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e                        state;
  logic [imuldiv_pkg::cnt_w-1:0] count;
  logic                          req_go;
  logic                          resp_go;
  logic                          last;
  logic                          step_en;
  logic                          result_en;

  // dividend magnitude shifts out the top while quotient bits fill the bottom
  logic [imuldiv_pkg::data_w-1:0] quot_reg;
  logic [imuldiv_pkg::data_w-1:0] rem_reg;
  logic [imuldiv_pkg::data_w-1:0] dvsr_reg;
  // quotient sign is the sign xor, remainder follows the dividend
  logic                           quot_neg;
  logic                           rem_neg;
  logic                           div_zero;

  logic                           a_sign;
  logic                           b_sign;
  logic [imuldiv_pkg::data_w-1:0] a_mag;
  logic [imuldiv_pkg::data_w-1:0] b_mag;
  logic [imuldiv_pkg::data_w:0]   rem_shift;
  logic [imuldiv_pkg::data_w+1:0] diff;
  logic                           q_bit;

  // --------------------
  // control
  // --------------------

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_go    = req_val & req_rdy;
  assign resp_go   = resp_val & resp_rdy;
  assign last      = (count == imuldiv_pkg::cnt_last);
  assign step_en   = (state == st_calc) & !last;
  assign result_en = (state == st_calc) & last;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  assign a_sign = is_signed & a[imuldiv_pkg::data_w-1];
  assign b_sign = is_signed & b[imuldiv_pkg::data_w-1];
  assign a_mag  = a_sign ? (~a + 1'b1) : a;
  assign b_mag  = b_sign ? (~b + 1'b1) : b;

  // bring down the next dividend bit
  assign rem_shift = {rem_reg, quot_reg[imuldiv_pkg::data_w-1]};
  // one extra bit so a borrow shows up as the sign
  assign diff  = {1'b0, rem_shift} - {2'b00, dvsr_reg};
  assign q_bit = ~diff[imuldiv_pkg::data_w+1];

  always_ff @(posedge clk) begin
    if (req_go) begin
      quot_reg <= a_mag;
      rem_reg  <= '0;
      dvsr_reg <= b_mag;
      quot_neg <= a_sign ^ b_sign;
      rem_neg  <= a_sign;
      div_zero <= (b == '0);
    end else if (step_en) begin
      // keep the difference only when it did not borrow
      rem_reg  <= q_bit ? diff[imuldiv_pkg::data_w-1:0] : rem_shift[imuldiv_pkg::data_w-1:0];
      quot_reg <= {quot_reg[imuldiv_pkg::data_w-2:0], q_bit};
    end
  end

  // with a zero divisor every step subtracts nothing, so the remainder
  // ends as the dividend magnitude and its sign restore gives back the
  // original dividend; only the quotient needs forcing
  always_ff @(posedge clk) begin
    if (result_en) begin
      if (div_zero) begin
        result.quot <= '1;
      end else begin
        result.quot <= quot_neg ? (~quot_reg + 1'b1) : quot_reg;
      end
      result.rem <= rem_neg ? (~rem_reg + 1'b1) : rem_reg;
    end
  end

endmodule

// ==== logic/imuldiv_unit.sv ====
// --------------------
// multiply/divide top: request dispatch by function,
// busy unit tracking and response return
// --------------------

`timescale 1ns/1ps

module imuldiv_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_u resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  // function decode
  logic is_div;
  logic is_signed;

  // low selects the multiplier, high the divider
  logic busy_sel;

  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;

  logic [imuldiv_pkg::prod_w-1:0] mul_result;
  imuldiv_pkg::div_result_t       div_result;

  // multiplier control to datapath
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;
  logic result_en;

  // --------------------
  // dispatch
  // --------------------

  assign is_div    = (req.func == imuldiv_pkg::func_div) | (req.func == imuldiv_pkg::func_divu);
  assign is_signed = (req.func == imuldiv_pkg::func_mul) | (req.func == imuldiv_pkg::func_div);

  // one operation in flight, so both units must be idle
  assign req_rdy = mul_req_rdy & div_req_rdy;

  // valid only reaches a unit when the top level is accepting
  assign mul_req_val = req_val & req_rdy & ~is_div;
  assign div_req_val = req_val & req_rdy & is_div;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_sel <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy_sel <= is_div;
    end
  end

  // --------------------
  // response return
  // --------------------

  assign resp_val     = busy_sel ? div_resp_val : mul_resp_val;
  assign mul_resp_rdy = resp_rdy & ~busy_sel;
  assign div_resp_rdy = resp_rdy & busy_sel;

  always_comb begin
    resp.product = mul_result;
    if (busy_sel) begin
      resp.div = div_result;
    end
  end

  // --------------------
  // units
  // --------------------

  int_mul_ctrl mul_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .req_val   (mul_req_val),
    .req_rdy   (mul_req_rdy),
    .resp_val  (mul_resp_val),
    .resp_rdy  (mul_resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel),
    .result_en (result_en)
  );

  int_mul_dpath mul_dpath_i (
    .clk       (clk),
    .reset     (reset),
    .a         (req.a),
    .b         (req.b),
    .is_signed (is_signed),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel),
    .result_en (result_en),
    .result    (mul_result)
  );

  int_div_iterative div_i (
    .clk       (clk),
    .reset     (reset),
    .a         (req.a),
    .b         (req.b),
    .is_signed (is_signed),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy),
    .result    (div_result)
  );

endmodule

// ==== tests/imuldiv_unit_tb.sv ====
// --------------------
// testbench for imuldiv_unit: clock, reset, LFSR stimulus,
// reference model and checking assertions
// --------------------

`timescale 1ns/1ps

module imuldiv_unit_tb;

  // resp_val rises on this edge counted from the accepting edge
  localparam int resp_latency = 33;
  localparam int wait_limit   = 200;

  logic                      clk;
  logic                      reset;
  imuldiv_pkg::muldiv_req_t  req;
  logic                      req_val;
  logic                      req_rdy;
  imuldiv_pkg::muldiv_resp_u resp;
  logic                      resp_val;
  logic                      resp_rdy;

  // expected response of the operation in flight
  imuldiv_pkg::muldiv_resp_u exp_word;
  logic                      exp_is_div;

  // edge tracking for the handshake checks
  logic                      in_flight;
  int                        cycles;
  logic                      held;
  imuldiv_pkg::muldiv_resp_u prev_word;

  logic [31:0] lfsr;
  logic [31:0] corner [4];
  int          err_count;
  int          op_count;
  logic        timed_out;

  imuldiv_unit imuldiv_unit_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #50 clk = ~clk;

  // --------------------
  // stimulus helpers
  // --------------------

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r[i] = lfsr[0];
    end
    return r;
  endfunction

  // behavioral reference, division truncates toward zero
  function automatic imuldiv_pkg::muldiv_resp_u model(input imuldiv_pkg::muldiv_req_t r);
    imuldiv_pkg::muldiv_resp_u w;
    longint                    sa;
    longint                    sb;
    w  = '0;
    sa = longint'($signed(r.a));
    sb = longint'($signed(r.b));
    case (r.func)
      imuldiv_pkg::func_mul: w.product = sa * sb;
      imuldiv_pkg::func_mulu: w.product = {32'b0, r.a} * {32'b0, r.b};
      default: begin
        if (r.b == 32'b0) begin
          // zero divisor: all ones quotient, dividend as remainder
          w.div.quot = '1;
          w.div.rem  = r.a;
        end else if (r.func == imuldiv_pkg::func_div) begin
          // min / -1 wraps back onto min in 32 bits
          w.div.quot = 32'(sa / sb);
          w.div.rem  = 32'(sa % sb);
        end else begin
          w.div.quot = r.a / r.b;
          w.div.rem  = r.a % r.b;
        end
      end
    endcase
    return w;
  endfunction

  // full transaction: request, wait, random back-pressure, transfer
  task automatic send_op(input imuldiv_pkg::muldiv_func_e f, input logic [31:0] a,
                         input logic [31:0] b);
    imuldiv_pkg::muldiv_req_t r;
    int                       waited;
    int                       hold;
    if (timed_out) begin
      return;
    end
    r.func     = f;
    r.a        = a;
    r.b        = b;
    exp_word   = model(r);
    exp_is_div = (f == imuldiv_pkg::func_div) || (f == imuldiv_pkg::func_divu);
    req        = r;
    req_val    = 1'b1;
    waited     = 0;
    // ready seen here means the next edge accepts
    while (!req_rdy) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > wait_limit) begin
        $display("timeout: request was never accepted at %0t", $time);
        timed_out = 1'b1;
        return;
      end
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
    waited  = 0;
    while (!resp_val) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > wait_limit) begin
        $display("timeout: response valid never rose at %0t", $time);
        timed_out = 1'b1;
        return;
      end
    end
    hold = take_bits(3);
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      #1;
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
    op_count++;
  endtask

  // --------------------
  // checks
  // --------------------

  always @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
      cycles    <= 0;
      held      <= 1'b0;
    end else begin
      if (req_val && req_rdy) begin
        in_flight <= 1'b1;
        cycles    <= 0;
      end else if (in_flight && !resp_val) begin
        cycles <= cycles + 1;
      end
      if (resp_val && resp_rdy) begin
        in_flight <= 1'b0;
      end
      held <= resp_val && !resp_rdy;
    end
    prev_word <= resp;
  end

  check_rdy_after_reset: assert property (@(posedge clk) $fell(reset) |-> req_rdy)
    else begin
      err_count = err_count + 1;
      $display("ERR %0t req_rdy expected 1 got %b", $time, $sampled(req_rdy));
    end

  check_val_after_reset: assert property (@(posedge clk) $fell(reset) |-> !resp_val)
    else begin
      err_count = err_count + 1;
      $display("ERR %0t resp_val expected 0 got %b", $time, $sampled(resp_val));
    end

  // no second request while one is in flight
  check_busy: assert property (@(posedge clk) disable iff (reset) in_flight |-> !req_rdy)
    else begin
      err_count = err_count + 1;
      $display("ERR %0t req_rdy expected 0 got %b", $time, $sampled(req_rdy));
    end

  check_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> (cycles == resp_latency))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t resp_val latency expected %0d got %0d", $time, resp_latency,
               $sampled(cycles));
    end

  check_product: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && !exp_is_div) |-> (resp.product == exp_word.product))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t resp.product expected %h got %h", $time,
               $sampled(exp_word.product), $sampled(resp.product));
    end

  check_quot: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && exp_is_div) |-> (resp.div.quot == exp_word.div.quot))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t resp.div.quot expected %h got %h", $time,
               $sampled(exp_word.div.quot), $sampled(resp.div.quot));
    end

  check_rem: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && exp_is_div) |-> (resp.div.rem == exp_word.div.rem))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t resp.div.rem expected %h got %h", $time,
               $sampled(exp_word.div.rem), $sampled(resp.div.rem));
    end

  // back-pressure keeps valid and the word unchanged
  check_hold_val: assert property (@(posedge clk) disable iff (reset) held |-> resp_val)
    else begin
      err_count = err_count + 1;
      $display("ERR %0t resp_val expected 1 got %b", $time, $sampled(resp_val));
    end

  check_hold_word: assert property (@(posedge clk) disable iff (reset)
    held |-> (resp.product == prev_word.product))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t resp.product expected %h got %h", $time,
               $sampled(prev_word.product), $sampled(resp.product));
    end

  // --------------------
  // sequence
  // --------------------

  initial begin
    logic [31:0] fbits;
    clk       = 1'b0;
    reset     = 1'b1;
    req       = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    exp_word  = '0;
    exp_is_div = 1'b0;
    lfsr      = 32'hc41b66cc;
    err_count = 0;
    op_count  = 0;
    timed_out = 1'b0;
    corner    = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000};

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // multiply corners, both signednesses
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        send_op(imuldiv_pkg::func_mul, corner[i], corner[j]);
        send_op(imuldiv_pkg::func_mulu, corner[i], corner[j]);
      end
    end

    // mixed signs, zero divisor and min / -1
    send_op(imuldiv_pkg::func_div, 32'd100, -32'sd7);
    send_op(imuldiv_pkg::func_div, -32'sd100, 32'd7);
    send_op(imuldiv_pkg::func_div, -32'sd100, -32'sd7);
    send_op(imuldiv_pkg::func_divu, -32'sd100, 32'd7);
    send_op(imuldiv_pkg::func_div, -32'sd5, 32'd0);
    send_op(imuldiv_pkg::func_divu, 32'hdeadbeef, 32'd0);
    send_op(imuldiv_pkg::func_div, 32'h80000000, 32'hffffffff);
    send_op(imuldiv_pkg::func_divu, 32'h80000000, 32'hffffffff);

    // random mix, divisors spread over many magnitudes
    for (int k = 0; k < 48; k++) begin
      fbits = take_bits(2);
      send_op(imuldiv_pkg::muldiv_func_e'(fbits[1:0]), take_bits(32),
              take_bits(32) >> take_bits(5));
    end

    $display("errors: %0d  operations: %0d  timeouts: %0d", err_count, op_count,
             timed_out);
    if (err_count == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/imuldiv_pkg.sv
logic/int_mul_dpath.sv
logic/int_mul_ctrl.sv
logic/int_div_iterative.sv
logic/imuldiv_unit.sv
tests/imuldiv_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the imuldiv_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module imuldiv_unit_tb \
  -Mdir obj_dir

out="$(./obj_dir/Vimuldiv_unit_tb)"
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi
